/* alu_health_monitor.f */
verilog/alu_ft_pkg.sv
verilog/ft_csr_pkg.sv
verilog/alu_op_classifier.sv
verilog/ft_csr_access.sv
verilog/err_counter_bank.sv
verilog/fault_flag_register.sv
verilog/alu_health_monitor.sv
verif/alu_health_assertions.sv
verif/tb_alu_health_monitor.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ALU health monitor testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_alu_health_monitor \
  -f alu_health_monitor.f -o sim_tb \
  && { ./obj_dir/sim_tb > sim.log 2>&1 || true; } \
  || { echo "Build failed"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test passed" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"

/* verif/tb_alu_health_monitor.sv */
`timescale 1ns/10ps
`default_nettype none
////////////////////////////////////////
// ALU health monitor testbench
// Xorshift stimulus from a fixed seed
// Reference model of counters and flags
// Compare tasks and per test report
////////////////////////////////////////

module tb_alu_health_monitor;

  import alu_ft_pkg::*;
  import ft_csr_pkg::*;

  localparam int CLK_PERIOD = 40;
  // Cycle budget of any wait loop
  localparam int WAIT_LIMIT = 64;
  localparam int NUM_OPS    = 18;

  // Listed operators in class order with two per class
  localparam alu_op_t OP_LIST [NUM_OPS] = '{
    OP_ADD, OP_SRL, OP_XOR, OP_AND, OP_BSET, OP_BCLR, OP_CNT, OP_FF1, OP_SHUF,
    OP_EXT, OP_LTS, OP_EQ, OP_ABS, OP_CLIP, OP_MIN, OP_MAX, OP_DIV, OP_REM
  };

  logic                        clock_gated;
  logic                        rst_n;
  alu_event_t  [NUM_LANES-1:0] events;
  logic                        div_ready;
  ft_csr_req_t                 csr_req;
  csr_data_t                   csr_rdata;
  lane_flags_t [NUM_LANES-1:0] fault_flags;

  // Model counters and flags
  err_count_t  m_cnt [NUM_LANES][NUM_CLASSES];
  lane_flags_t m_flags [NUM_LANES];

  logic [31:0] rng;
  int          checks;
  int          errors;
  int          test_errors;

  alu_health_monitor uut (
    .clock_gated   (clock_gated),
    .rst_n         (rst_n),
    .events_i      (events),
    .div_ready_i   (div_ready),
    .csr_req_i     (csr_req),
    .csr_rdata_o   (csr_rdata),
    .fault_flags_o (fault_flags)
  );

  initial clock_gated = 1'b0;
  always #(CLK_PERIOD/2) clock_gated = ~clock_gated;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Class index from list position or -1 when unlisted
  function automatic int expected_class(input alu_op_t op);
    int cls;
    cls = -1;
    for (int i = 0; i < NUM_OPS; i++) begin
      if (op == OP_LIST[i]) begin
        cls = i / 2;
      end
    end
    return cls;
  endfunction

  function automatic csr_addr_t cnt_addr(input int l, input int c);
    return FT_CNT_BASE + csr_addr_t'(NUM_LANES*c + l);
  endfunction

  // Map words from model flags and zero for any other address
  function automatic csr_data_t expected_read(input csr_addr_t addr);
    csr_data_t d;
    d = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int c = 0; c < DIV_CLASS; c++) begin
        if (addr == FT_MAP_LO_ADDR) begin
          d[NUM_LANES*c + l] = m_flags[l][c];
        end
      end
      if (addr == FT_MAP_HI_ADDR) begin
        d[l] = m_flags[l][DIV_CLASS];
      end
    end
    return d;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  task automatic step_model();
    logic csr_wr;
    logic old_flag;
    int   cls;
    csr_wr = csr_req.we && !csr_req.re;
    for (int l = 0; l < NUM_LANES; l++) begin
      cls = expected_class(events[l].op);
      for (int c = 0; c < NUM_CLASSES; c++) begin
        old_flag = m_flags[l][c];
        // Flag follows the counter value before this edge
        m_flags[l][c] = old_flag | (m_cnt[l][c] >= ERR_THRESHOLD);
        if (csr_wr && c < DIV_CLASS && csr_req.addr == FT_MAP_LO_ADDR) begin
          m_flags[l][c] = csr_req.wdata[NUM_LANES*c + l];
        end
        if (csr_wr && c == DIV_CLASS && csr_req.addr == FT_MAP_HI_ADDR) begin
          m_flags[l][c] = csr_req.wdata[l];
        end
        if (csr_wr && csr_req.addr == cnt_addr(l, c)) begin
          m_cnt[l][c] = csr_req.wdata;
        end else if (old_flag) begin
          m_cnt[l][c] = '0;
        end else if (events[l].enable && cls == c && (c != DIV_CLASS || div_ready)) begin
          if (events[l].error) begin
            m_cnt[l][c] = m_cnt[l][c] + ERR_INCREASE;
          end else begin
            m_cnt[l][c] = (m_cnt[l][c] > ERR_DECREASE) ? m_cnt[l][c] - ERR_DECREASE : '0;
          end
        end
      end
    end
  endtask

  always @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        m_flags[l] = '0;
        for (int c = 0; c < NUM_CLASSES; c++) begin
          m_cnt[l][c] = '0;
        end
      end
    end else begin
      step_model();
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_count(input err_count_t got, input err_count_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL %0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input lane_flags_t got, input lane_flags_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL %0t: %s flags %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_rdata(input csr_data_t got, input csr_data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  task automatic drive(input alu_event_t [NUM_LANES-1:0] ev, input logic dr,
                       input ft_csr_req_t req);
    @(posedge clock_gated);
    events    <= ev;
    div_ready <= dr;
    csr_req   <= req;
  endtask

  // Read when re is set and write otherwise
  function automatic ft_csr_req_t make_req(input csr_addr_t addr, input logic re,
                                           input csr_data_t wdata);
    ft_csr_req_t req;
    req.addr  = addr;
    req.re    = re;
    req.we    = !re;
    req.wdata = wdata;
    return req;
  endfunction

  function automatic alu_event_t random_event();
    logic [31:0] r;
    alu_event_t  ev;
    int          idx;
    r         = rand32();
    idx       = int'(r[31:16] % 16'd18);
    ev.enable = r[1:0] != 2'b00;
    // Low error rate of about 3 in 16
    ev.error  = r[7:4] < 4'd3;
    ev.op     = (r[11:8] == 4'h0) ? r[18:12] : OP_LIST[idx];
    return ev;
  endfunction

  task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
    drive('0, 1'b0, make_req(addr, 1'b0, data));
  endtask

  task automatic read_counter(input int l, input int c);
    drive('0, 1'b0, make_req(cnt_addr(l, c), 1'b1, '0));
    @(negedge clock_gated);
    check_count(err_count_t'(csr_rdata), m_cnt[l][c], $sformatf("lane %0d class %0d", l, c));
  endtask

  task automatic read_word(input csr_addr_t addr, input string what);
    drive('0, 1'b0, make_req(addr, 1'b1, '0));
    @(negedge clock_gated);
    check_rdata(csr_rdata, expected_read(addr), what);
  endtask

  task automatic read_all_counters();
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int c = 0; c < NUM_CLASSES; c++) begin
        read_counter(l, c);
      end
    end
  endtask

  task automatic check_all_flags();
    for (int l = 0; l < NUM_LANES; l++) begin
      check_flags(fault_flags[l], m_flags[l], $sformatf("lane %0d", l));
    end
  endtask

  task automatic end_test(input string name);
    $display("%-14s done, %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_reset();
    drive('0, 1'b0, '0);
    @(negedge clock_gated);
    check_rdata(csr_rdata, '0, "idle");
    read_all_counters();
    check_all_flags();
    read_word(FT_MAP_LO_ADDR, "map lo");
    read_word(FT_MAP_HI_ADDR, "map hi");
    end_test("reset");
  endtask

  task automatic test_leaky_bucket();
    alu_event_t [NUM_LANES-1:0] ev;
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < 50; i++) begin
        for (int l = 0; l < NUM_LANES; l++) begin
          ev[l] = random_event();
        end
        drive(ev, rng[20], '0);
      end
      read_all_counters();
      check_all_flags();
    end
    // Unlisted operator with errors on every lane
    for (int l = 0; l < NUM_LANES; l++) begin
      ev[l].enable = 1'b1;
      ev[l].op     = 7'h7F;
      ev[l].error  = 1'b1;
    end
    repeat (8) drive(ev, 1'b1, '0);
    read_all_counters();
    end_test("leaky bucket");
  endtask

  task automatic test_threshold();
    alu_event_t [NUM_LANES-1:0] ev;
    int                         cycles;
    // Clear counters first and flags after
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int c = 0; c < NUM_CLASSES; c++) begin
        csr_write(cnt_addr(l, c), '0);
      end
    end
    csr_write(FT_MAP_LO_ADDR, '0);
    csr_write(FT_MAP_HI_ADDR, '0);
    @(negedge clock_gated);
    ev           = '0;
    ev[2].enable = 1'b1;
    ev[2].op     = OP_CNT;
    ev[2].error  = 1'b1;
    cycles       = 0;
    while (!fault_flags[2][3] && cycles < WAIT_LIMIT) begin
      drive(ev, 1'b0, '0);
      @(negedge clock_gated);
      check_flags(fault_flags[2], m_flags[2], "lane 2 counting");
      cycles++;
    end
    if (!fault_flags[2][3]) begin
      errors++;
      test_errors++;
      $display("ERROR %0t: fault flag lane 2 class 3 not set after %0d cycles",
               $time, WAIT_LIMIT);
    end
    // Let the flag park its counter
    repeat (2) drive('0, 1'b0, '0);
    @(negedge clock_gated);
    check_all_flags();
    check_flags(fault_flags[2], 9'b0_0000_1000, "lane 2 exact");
    read_word(FT_MAP_LO_ADDR, "map lo");
    check_rdata(csr_rdata, 32'h0000_4000, "map lo bit 14");
    read_counter(2, 3);
    check_count(err_count_t'(csr_rdata), '0, "held counter");
    end_test("threshold");
  endtask

  task automatic test_div_gating();
    alu_event_t [NUM_LANES-1:0] ev;
    csr_write(cnt_addr(1, DIV_CLASS), '0);
    ev           = '0;
    ev[1].enable = 1'b1;
    ev[1].op     = OP_DIV;
    ev[1].error  = 1'b1;
    // Divider busy so nothing counts
    repeat (3) drive(ev, 1'b0, '0);
    read_counter(1, DIV_CLASS);
    check_count(err_count_t'(csr_rdata), '0, "divider busy");
    ev[1].op = OP_REM;
    repeat (3) drive(ev, 1'b1, '0);
    read_counter(1, DIV_CLASS);
    check_count(err_count_t'(csr_rdata), ERR_INCREASE * 3, "divider done");
    end_test("div gating");
  endtask

  task automatic test_csr_writes();
    alu_event_t [NUM_LANES-1:0] ev;
    csr_addr_t                  addr;
    logic [31:0]                r;
    // Counter write against an error event in the same cycle
    ev           = '0;
    ev[0].enable = 1'b1;
    ev[0].op     = OP_XOR;
    ev[0].error  = 1'b1;
    drive(ev, 1'b0, make_req(cnt_addr(0, 1), 1'b0, 32'd5));
    read_counter(0, 1);
    check_count(err_count_t'(csr_rdata), 32'd5, "write over event");
    // Counter written above threshold
    csr_write(cnt_addr(3, 5), 32'd12);
    repeat (2) drive('0, 1'b0, '0);
    @(negedge clock_gated);
    check_all_flags();
    // Random map words set and clear flags
    csr_write(FT_MAP_LO_ADDR, rand32());
    csr_write(FT_MAP_HI_ADDR, rand32());
    drive('0, 1'b0, '0);
    @(negedge clock_gated);
    check_all_flags();
    read_word(FT_MAP_LO_ADDR, "map lo");
    read_word(FT_MAP_HI_ADDR, "map hi");
    read_all_counters();
    // Unmapped addresses
    read_word(12'hB07, "below base");
    read_word(12'hB2E, "above map");
    for (int i = 0; i < 8; i++) begin
      r    = rand32();
      addr = r[11:0];
      if (addr < FT_CNT_BASE || addr > FT_MAP_HI_ADDR) begin
        read_word(addr, $sformatf("unmapped %h", addr));
        check_rdata(csr_rdata, '0, "unmapped zero");
      end
    end
    end_test("csr writes");
  endtask

  initial begin
    rng         = 32'd84;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    rst_n       = 1'b0;
    events      = '0;
    div_ready   = 1'b0;
    csr_req     = '0;
    repeat (4) @(posedge clock_gated);
    rst_n <= 1'b1;
    test_reset();
    test_leaky_bucket();
    test_threshold();
    test_div_gating();
    test_csr_writes();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/alu_health_assertions.sv */
`timescale 1ns/10ps
`default_nettype none
////////////////////////////////////////
// Fault flag register assertions
// Sticky flags, map strobes, set rule
// Bind onto fault_flag_register
////////////////////////////////////////

module alu_health_assertions (
  input logic clock_gated,
  input logic rst_n,
  input alu_ft_pkg::err_count_t [alu_ft_pkg::NUM_LANES-1:0][alu_ft_pkg::NUM_CLASSES-1:0]
                                counts_i,
  input logic map_lo_we_i,
  input logic map_hi_we_i,
  input alu_ft_pkg::lane_flags_t [alu_ft_pkg::NUM_LANES-1:0] flags_i
);

  import alu_ft_pkg::*;

  // One map word per write
  map_strobe_excl: assert property (@(posedge clock_gated) disable iff (!rst_n)
    !(map_lo_we_i && map_hi_we_i))
    else $error("both fault map write strobes high");

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_class
      logic map_we;
      // Map word that owns this flag
      assign map_we = (c < DIV_CLASS) ? map_lo_we_i : map_hi_we_i;

      flag_sticky: assert property (@(posedge clock_gated) disable iff (!rst_n)
        (flags_i[l][c] && !map_we) |=> flags_i[l][c])
        else $error("flag lane %0d class %0d cleared without map write", l, c);

      flag_needs_threshold: assert property (@(posedge clock_gated) disable iff (!rst_n)
        (!flags_i[l][c] && !map_we && counts_i[l][c] < ERR_THRESHOLD) |=> !flags_i[l][c])
        else $error("flag lane %0d class %0d set below threshold", l, c);
    end
  end

endmodule

bind fault_flag_register alu_health_assertions u_assertions (
  .clock_gated (clock_gated),
  .rst_n       (rst_n),
  .counts_i    (counts_i),
  .map_lo_we_i (map_lo_we_i),
  .map_hi_we_i (map_hi_we_i),
  .flags_i     (flags_o)
);

`default_nettype wire

/* verilog/alu_health_monitor.sv */
`timescale 1ns/10ps
`default_nettype none
////////////////////////////////////////
// ALU health monitor top level
// Per lane classifier and counter bank
// CSR access and fault flag register
////////////////////////////////////////

module alu_health_monitor (
  input  logic                    clock_gated,
  input  logic                    rst_n,
  input  alu_ft_pkg::alu_event_t  [alu_ft_pkg::NUM_LANES-1:0] events_i,
  input  logic                    div_ready_i,
  input  ft_csr_pkg::ft_csr_req_t csr_req_i,
  output ft_csr_pkg::csr_data_t   csr_rdata_o,
  output alu_ft_pkg::lane_flags_t [alu_ft_pkg::NUM_LANES-1:0] fault_flags_o
);

  import alu_ft_pkg::*;
  import ft_csr_pkg::*;

  class_sel_t  [NUM_LANES-1:0]                  lane_class;
  class_sel_t  [NUM_LANES-1:0]                  cnt_we;
  err_count_t  [NUM_LANES-1:0][NUM_CLASSES-1:0] counts;
  lane_flags_t [NUM_LANES-1:0]                  flags;
  logic                                         map_lo_we;
  logic                                         map_hi_we;
  csr_data_t                                    wr_data;

  ////////////////////////////////////////
  // Per lane datapath
  ////////////////////////////////////////
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    alu_op_classifier u_classifier (
      .op_i    (events_i[l].op),
      .class_o (lane_class[l])
    );

    err_counter_bank u_bank (
      .clock_gated (clock_gated),
      .rst_n       (rst_n),
      .event_i     (events_i[l]),
      .class_i     (lane_class[l]),
      .div_ready_i (div_ready_i),
      .flags_i     (flags[l]),
      .cnt_we_i    (cnt_we[l]),
      .wr_data_i   (wr_data),
      .counts_o    (counts[l])
    );
  end

  // CSR decode and read mux
  ft_csr_access u_csr_access (
    .csr_req_i   (csr_req_i),
    .counts_i    (counts),
    .flags_i     (flags),
    .cnt_we_o    (cnt_we),
    .map_lo_we_o (map_lo_we),
    .map_hi_we_o (map_hi_we),
    .wr_data_o   (wr_data),
    .rdata_o     (csr_rdata_o)
  );

  // Threshold compare and sticky flags
  fault_flag_register u_flags (
    .clock_gated (clock_gated),
    .rst_n       (rst_n),
    .counts_i    (counts),
    .map_lo_we_i (map_lo_we),
    .map_hi_we_i (map_hi_we),
    .wr_data_i   (wr_data),
    .flags_o     (flags)
  );

  assign fault_flags_o = flags;

endmodule

`default_nettype wire

/* verilog/fault_flag_register.sv */
`timescale 1ns/10ps
`default_nettype none
////////////////////////////////////////
// Sticky fault flags, 4 lanes x 9 classes
// Threshold compare on every counter
// Fault map write from the CSR port
////////////////////////////////////////

module fault_flag_register (
  input  logic                  clock_gated,
  input  logic                  rst_n,
  input  alu_ft_pkg::err_count_t [alu_ft_pkg::NUM_LANES-1:0][alu_ft_pkg::NUM_CLASSES-1:0]
                                counts_i,
  input  logic                  map_lo_we_i,
  input  logic                  map_hi_we_i,
  input  ft_csr_pkg::csr_data_t wr_data_i,
  output alu_ft_pkg::lane_flags_t [alu_ft_pkg::NUM_LANES-1:0] flags_o
);

  import alu_ft_pkg::*;

  lane_flags_t [NUM_LANES-1:0] flags_q;
  lane_flags_t [NUM_LANES-1:0] flags_d;

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int c = 0; c < NUM_CLASSES; c++) begin
        // Sticky set once the counter reaches the threshold
        flags_d[l][c] = flags_q[l][c] | (counts_i[l][c] >= ERR_THRESHOLD);
        // Map write reloads the flag, set or clear
        if (c < DIV_CLASS) begin
          if (map_lo_we_i) begin
            flags_d[l][c] = wr_data_i[NUM_LANES*c + l];
          end
        end else if (map_hi_we_i) begin
          flags_d[l][c] = wr_data_i[l];
        end
      end
    end
  end

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_d;
    end
  end

  assign flags_o = flags_q;

endmodule

`default_nettype wire

/* verilog/err_counter_bank.sv */
`timescale 1ns/10ps
`default_nettype none
////////////////////////////////////////
// Leaky bucket error counters
// Nine counters for one ALU lane
// Event step, fault hold, CSR load
////////////////////////////////////////

module err_counter_bank (
  input  logic                    clock_gated,
  input  logic                    rst_n,
  input  alu_ft_pkg::alu_event_t  event_i,
  input  alu_ft_pkg::class_sel_t  class_i,
  input  logic                    div_ready_i,
  input  alu_ft_pkg::lane_flags_t flags_i,
  input  alu_ft_pkg::class_sel_t  cnt_we_i,
  input  ft_csr_pkg::csr_data_t   wr_data_i,
  output alu_ft_pkg::err_count_t [alu_ft_pkg::NUM_CLASSES-1:0] counts_o
);

  import alu_ft_pkg::*;

  class_sel_t                   step_en;
  err_count_t [NUM_CLASSES-1:0] count_q;
  err_count_t [NUM_CLASSES-1:0] count_d;

  // Which counter steps this cycle
  always_comb begin
    for (int c = 0; c < NUM_CLASSES; c++) begin
      step_en[c] = event_i.enable & class_i[c];
    end
    // Divider result only valid while it reports done
    step_en[DIV_CLASS] = step_en[DIV_CLASS] & div_ready_i;
  end

  ////////////////////////////////////////
  // Next counter values
  ////////////////////////////////////////
  always_comb begin
    for (int c = 0; c < NUM_CLASSES; c++) begin
      count_d[c] = count_q[c];
      if (cnt_we_i[c]) begin
        // CSR write beats everything
        count_d[c] = wr_data_i;
      end else if (flags_i[c]) begin
        // Faulty unit, counter parked at zero
        count_d[c] = '0;
      end else if (step_en[c]) begin
        if (event_i.error) begin
          count_d[c] = count_q[c] + ERR_INCREASE;
        end else if (count_q[c] >= ERR_DECREASE) begin
          count_d[c] = count_q[c] - ERR_DECREASE;
        end else begin
          // Floor at zero
          count_d[c] = '0;
        end
      end
    end
  end

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign counts_o = count_q;

endmodule

`default_nettype wire

/* verilog/ft_csr_access.sv */
`timescale 1ns/10ps
`default_nettype none
////////////////////////////////////////
// Fault monitor CSR access
// Address decode into write strobes
// Fault map packing
// Combinational read data mux
////////////////////////////////////////

module ft_csr_access (
  input  ft_csr_pkg::ft_csr_req_t csr_req_i,
  input  alu_ft_pkg::err_count_t [alu_ft_pkg::NUM_LANES-1:0][alu_ft_pkg::NUM_CLASSES-1:0]
                                  counts_i,
  input  alu_ft_pkg::lane_flags_t [alu_ft_pkg::NUM_LANES-1:0] flags_i,
  output alu_ft_pkg::class_sel_t [alu_ft_pkg::NUM_LANES-1:0]  cnt_we_o,
  output logic                    map_lo_we_o,
  output logic                    map_hi_we_o,
  output ft_csr_pkg::csr_data_t   wr_data_o,
  output ft_csr_pkg::csr_data_t   rdata_o
);

  import alu_ft_pkg::*;
  import ft_csr_pkg::*;

  logic      wr_en;
  csr_data_t map_lo;
  csr_data_t map_hi;

  // Read has priority, write only without read
  assign wr_en     = csr_req_i.we & ~csr_req_i.re;
  assign wr_data_o = csr_req_i.wdata;

  // Pack the flags into the two map words
  always_comb begin
    map_lo = '0;
    map_hi = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int c = 0; c < DIV_CLASS; c++) begin
        map_lo[NUM_LANES*c + l] = flags_i[l][c];
      end
      // Upper bits stay zero
      map_hi[l] = flags_i[l][DIV_CLASS];
    end
  end

  ////////////////////////////////////////
  // Decode and read mux
  ////////////////////////////////////////
  always_comb begin
    rdata_o     = '0;
    cnt_we_o    = '0;
    map_lo_we_o = 1'b0;
    map_hi_we_o = 1'b0;
    // Counter slots, class-major then lane
    for (int l = 0; l < NUM_LANES; l++) begin
      for (int c = 0; c < NUM_CLASSES; c++) begin
        if (csr_req_i.addr == FT_CNT_BASE + csr_addr_t'(NUM_LANES*c + l)) begin
          if (csr_req_i.re) begin
            rdata_o = counts_i[l][c];
          end
          cnt_we_o[l][c] = wr_en;
        end
      end
    end
    // Map words
    if (csr_req_i.addr == FT_MAP_LO_ADDR) begin
      if (csr_req_i.re) begin
        rdata_o = map_lo;
      end
      map_lo_we_o = wr_en;
    end
    if (csr_req_i.addr == FT_MAP_HI_ADDR) begin
      if (csr_req_i.re) begin
        rdata_o = map_hi;
      end
      map_hi_we_o = wr_en;
    end
  end

endmodule

`default_nettype wire

/* verilog/alu_op_classifier.sv */
`timescale 1ns/10ps
`default_nettype none
////////////////////////////////////////
// ALU operator classifier
// Maps one lane's operator onto a
// one-hot operation class
////////////////////////////////////////

module alu_op_classifier (
  input  alu_ft_pkg::alu_op_t    op_i,
  output alu_ft_pkg::class_sel_t class_o
);

  import alu_ft_pkg::*;

  always_comb begin
    class_o = '0;
    case (op_i)
      // Add and shift
      OP_ADD, OP_SRL:   class_o[0] = 1'b1;
      // Logic
      OP_XOR, OP_AND:   class_o[1] = 1'b1;
      // Bit manipulation
      OP_BSET, OP_BCLR: class_o[2] = 1'b1;
      // Bit counting
      OP_CNT, OP_FF1:   class_o[3] = 1'b1;
      // Shuffle and extract
      OP_SHUF, OP_EXT:  class_o[4] = 1'b1;
      // Comparisons
      OP_LTS, OP_EQ:    class_o[5] = 1'b1;
      // Absolute value and clip
      OP_ABS, OP_CLIP:  class_o[6] = 1'b1;
      // Min and max
      OP_MIN, OP_MAX:   class_o[7] = 1'b1;
      // Divider, gated by the divider ready in the bank
      OP_DIV, OP_REM:   class_o[DIV_CLASS] = 1'b1;
      // Unlisted operators touch no counter
      default:          class_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/ft_csr_pkg.sv */
`default_nettype none
////////////////////////////////////////
// Fault monitor CSR definitions
// Address and data types
// Counter and fault map addresses
// CSR request bundle
////////////////////////////////////////

package ft_csr_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // Counter of class c, lane l at base + 4c + l
  localparam csr_addr_t FT_CNT_BASE    = 12'hB08;
  // Flags of classes 0..7, bit 4c + l
  localparam csr_addr_t FT_MAP_LO_ADDR = 12'hB2C;
  // Division class flags in bits 3:0
  localparam csr_addr_t FT_MAP_HI_ADDR = 12'hB2D;

  // CSR port request
  typedef struct packed {
    csr_addr_t addr;
    logic      re;
    logic      we;
    csr_data_t wdata;
  } ft_csr_req_t;

endpackage

`default_nettype wire

/* verilog/alu_ft_pkg.sv */
`default_nettype none
////////////////////////////////////////
// ALU fault monitor definitions
// Lane and operation class counts
// Operator codes, two per class
// Leaky bucket counter policy
// Event, class and counter types
////////////////////////////////////////

package alu_ft_pkg;

  // Monitored lanes and operation classes
  localparam int NUM_LANES    = 4;
  localparam int NUM_CLASSES  = 9;
  localparam int DIV_CLASS    = 8;
  localparam int ALU_OP_WIDTH = 7;

  typedef logic [ALU_OP_WIDTH-1:0] alu_op_t;
  // One-hot class, all zero when the operator has no class
  typedef logic [NUM_CLASSES-1:0]  class_sel_t;
  typedef logic [31:0]             err_count_t;
  typedef logic [NUM_CLASSES-1:0]  lane_flags_t;

  ////////////////////////////////////////
  // Operator codes
  ////////////////////////////////////////
  localparam alu_op_t OP_ADD  = 7'b0011000;
  localparam alu_op_t OP_SRL  = 7'b0100101;
  localparam alu_op_t OP_XOR  = 7'b0101111;
  localparam alu_op_t OP_AND  = 7'b0010101;
  localparam alu_op_t OP_BSET = 7'b0101100;
  localparam alu_op_t OP_BCLR = 7'b0101011;
  localparam alu_op_t OP_CNT  = 7'b0110100;
  localparam alu_op_t OP_FF1  = 7'b0110110;
  localparam alu_op_t OP_SHUF = 7'b0111010;
  localparam alu_op_t OP_EXT  = 7'b0111111;
  localparam alu_op_t OP_LTS  = 7'b0000000;
  localparam alu_op_t OP_EQ   = 7'b0001100;
  localparam alu_op_t OP_ABS  = 7'b0010100;
  localparam alu_op_t OP_CLIP = 7'b0010110;
  localparam alu_op_t OP_MIN  = 7'b0010000;
  localparam alu_op_t OP_MAX  = 7'b0010010;
  localparam alu_op_t OP_DIV  = 7'b0110001;
  localparam alu_op_t OP_REM  = 7'b0110011;

  // Leaky bucket policy
  localparam err_count_t ERR_THRESHOLD = 32'd8;
  localparam err_count_t ERR_INCREASE  = 32'd2;
  localparam err_count_t ERR_DECREASE  = 32'd1;

  // One lane's report for one cycle
  typedef struct packed {
    logic    enable;
    alu_op_t op;
    logic    error;
  } alu_event_t;

endpackage

`default_nettype wire
